//--- hdl/zxvideo_pkg.sv
package zxvideo_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Source raster, counted in source pixels and lines
   ////////////////////////////////////////////////////////////////////////////

   localparam int h_total        = 448;
   localparam int v_total        = 312;
   localparam int h_active       = 256;
   localparam int v_active       = 192;
   // Both measured from the start of the sync pulse
   localparam int h_active_start = 96;
   localparam int v_active_start = 64;
   localparam int h_sync_len     = 32;
   localparam int v_sync_len     = 4;
   localparam int bar_width      = 32;

   // clk28 cycles per pixel on each side
   localparam int src_div        = 4;
   localparam int vga_div        = 2;

   localparam int h_cnt_w        = $clog2(h_total);
   localparam int v_cnt_w        = $clog2(v_total);
   localparam int frame_cnt_w    = 8;

   typedef logic [h_cnt_w-1:0] h_cnt_t;
   typedef logic [v_cnt_w-1:0] v_cnt_t;

   // 3 bits per channel
   typedef struct packed {
      logic [2:0] r;
      logic [2:0] g;
      logic [2:0] b;
   } pixel_t;

   ////////////////////////////////////////////////////////////////////////////
   // Wishbone register map
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [15:0] wb_data_t;
   typedef logic [1:0]  wb_addr_t;

   localparam wb_addr_t reg_ctrl_addr   = 2'd0;
   localparam wb_addr_t reg_border_addr = 2'd1;
   // Read only
   localparam wb_addr_t reg_frame_addr  = 2'd2;

   // Control register bits
   localparam int ctrl_vga_bit  = 0;
   localparam int ctrl_scan_bit = 1;

endpackage

//--- hdl/video_if.sv
`timescale 1ns/100ps

interface video_if
   import zxvideo_pkg::*;
();

   pixel_t pix;
   logic   hsync_n;
   logic   vsync_n;
   // Composite sync, low when either sync is low
   logic   csync_n;
   // One clk28 cycle per source pixel
   logic   pix_en;

   modport src (
      output pix,
      output hsync_n,
      output vsync_n,
      output csync_n,
      output pix_en
   );

   modport snk (
      input pix,
      input hsync_n,
      input vsync_n,
      input csync_n,
      input pix_en
   );

endinterface

//--- hdl/wb_video_regs.sv
`timescale 1ns/100ps

module wb_video_regs
   import zxvideo_pkg::*;
(
   input  logic     clk28,
   input  logic     rst_n,
   input  logic     cyc,
   input  logic     stb,
   input  logic     we,
   input  wb_addr_t adr,
   input  wb_data_t dat_w,
   output wb_data_t dat_r,
   output logic     ack,
   input  logic     frame_start,
   output logic     vga_enable,
   output logic     scanlines_enable,
   output pixel_t   border
);

   logic [1:0]             ctrl;
   logic [frame_cnt_w-1:0] frame_cnt;
   logic                   access;

   // New cycle seen, not yet acknowledged
   assign access = cyc && stb && !ack;

   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= access;
      end
   end

   // Writes land on the same edge that raises ack
   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         ctrl   <= '0;
         border <= '0;
      end else if (access && we) begin
         case (adr)
            reg_ctrl_addr:   ctrl   <= dat_w[1:0];
            reg_border_addr: border <= pixel_t'(dat_w[$bits(pixel_t)-1:0]);
            default: ;
         endcase
      end
   end

   // Free running, wraps at 255
   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         frame_cnt <= '0;
      end else if (frame_start) begin
         frame_cnt <= frame_cnt + 1'b1;
      end
   end

   // Read data, valid while ack is high
   always_ff @(posedge clk28) begin
      if (access) begin
         case (adr)
            reg_ctrl_addr:   dat_r <= wb_data_t'(ctrl);
            reg_border_addr: dat_r <= wb_data_t'(border);
            reg_frame_addr:  dat_r <= wb_data_t'(frame_cnt);
            default:         dat_r <= '0;
         endcase
      end
   end

   assign vga_enable       = ctrl[ctrl_vga_bit];
   assign scanlines_enable = ctrl[ctrl_scan_bit];

   // Master must see ack drop between two accesses
   a_ack_single: assert property (
      @(posedge clk28) disable iff (!rst_n)
      ack |=> !ack
   );

endmodule

//--- hdl/pal_timing_gen.sv
`timescale 1ns/100ps

module pal_timing_gen
   import zxvideo_pkg::*;
(
   input  logic   clk28,
   input  logic   rst_n,
   input  pixel_t border,
   output logic   frame_start,
   video_if.src   vid
);

   logic [$clog2(src_div)-1:0] div_cnt;
   logic                       tick;
   h_cnt_t                     h_cnt;
   v_cnt_t                     v_cnt;
   logic                       line_hs_n;
   logic                       line_vs_n;
   logic                       in_active;
   h_cnt_t                     act_x;
   logic [2:0]                 bar;
   pixel_t                     bar_pix;

   ////////////////////////////////////////////////////////////////////////////
   // Pixel clock enable and raster counters
   ////////////////////////////////////////////////////////////////////////////

   assign tick = (div_cnt == src_div - 1);

   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         div_cnt <= '0;
      end else if (tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // Position 0,0 is the first pixel of the vertical sync line
   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (tick) begin
         if (h_cnt == h_cnt_t'(h_total - 1)) begin
            h_cnt <= '0;
            if (v_cnt == v_cnt_t'(v_total - 1)) begin
               v_cnt <= '0;
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Syncs and pixel colour for the current position
   ////////////////////////////////////////////////////////////////////////////

   assign line_hs_n = !(h_cnt < h_sync_len);
   assign line_vs_n = !(v_cnt < v_sync_len);

   assign in_active = (h_cnt >= h_active_start) && (h_cnt < h_active_start + h_active) &&
                      (v_cnt >= v_active_start) && (v_cnt < v_active_start + v_active);

   // Bar index bits pick red, green, blue at full level
   assign act_x   = h_cnt - h_cnt_t'(h_active_start);
   assign bar     = 3'(act_x / bar_width);
   assign bar_pix = '{r: {3{bar[2]}}, g: {3{bar[1]}}, b: {3{bar[0]}}};

   // Everything toward the sink moves together, one clock after the counters
   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         vid.pix_en  <= 1'b0;
         vid.hsync_n <= 1'b1;
         vid.vsync_n <= 1'b1;
         vid.csync_n <= 1'b1;
         vid.pix     <= '0;
         frame_start <= 1'b0;
      end else begin
         vid.pix_en  <= tick;
         frame_start <= tick && (h_cnt == '0) && (v_cnt == '0);
         if (tick) begin
            vid.hsync_n <= line_hs_n;
            vid.vsync_n <= line_vs_n;
            vid.csync_n <= line_hs_n && line_vs_n;
            vid.pix     <= in_active ? bar_pix : border;
         end
      end
   end

   a_h_range: assert property (
      @(posedge clk28) disable iff (!rst_n)
      h_cnt < h_total
   );

   a_v_range: assert property (
      @(posedge clk28) disable iff (!rst_n)
      v_cnt < v_total
   );

endmodule

//--- hdl/vga_scandoubler.sv
`timescale 1ns/100ps

module vga_scandoubler
   import zxvideo_pkg::*;
(
   input  logic       clk28,
   input  logic       rst_n,
   video_if.snk       vid,
   input  logic       vga_enable,
   input  logic       scanlines_enable,
   output logic [2:0] r,
   output logic [2:0] g,
   output logic [2:0] b,
   output logic       hsync,
   output logic       vsync
);

   typedef logic [$clog2(2 * h_total)-1:0] buf_addr_t;

   // Bank 0 at the bottom, bank 1 from h_total up
   pixel_t line_buf [0:2*h_total-1];

   // Write side
   logic      hs_prev;
   logic      swap;
   logic      wr_bank;
   logic      wr_sel_bank;
   h_cnt_t    wr_addr;
   h_cnt_t    wr_sel_addr;
   buf_addr_t wr_idx;
   logic      wr_vs_n;

   // Read side
   logic [$clog2(vga_div)-1:0] vga_cnt;
   logic                       vga_tick;
   logic                       rd_bank;
   logic                       replay;
   logic                       rd_vs_n;
   h_cnt_t                     rd_addr;
   buf_addr_t                  rd_idx;

   // Doubled stage, aligned with the buffer read data
   pixel_t dbl_pix;
   logic   dbl_hs_n;
   logic   dbl_vs_n;
   logic   dbl_dim;
   pixel_t out_pix;

   function automatic pixel_t dim_pixel(input pixel_t p);
      pixel_t q;
      q.r = p.r >> 1;
      q.g = p.g >> 1;
      q.b = p.b >> 1;
      return q;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Line capture
   ////////////////////////////////////////////////////////////////////////////

   // Falling source hsync starts a new line in the other bank
   assign swap        = vid.pix_en && hs_prev && !vid.hsync_n;
   assign wr_sel_bank = swap ? ~wr_bank : wr_bank;
   assign wr_sel_addr = swap ? '0 : wr_addr;
   assign wr_idx      = buf_addr_t'(wr_sel_addr) + (wr_sel_bank ? buf_addr_t'(h_total) : '0);

   always_ff @(posedge clk28) begin
      if (vid.pix_en) begin
         line_buf[wr_idx] <= vid.pix;
      end
   end

   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         hs_prev <= 1'b1;
         wr_bank <= 1'b0;
         wr_addr <= '0;
         wr_vs_n <= 1'b1;
      end else if (vid.pix_en) begin
         hs_prev <= vid.hsync_n;
         wr_bank <= wr_sel_bank;
         // Hold at the last slot if a line runs long
         if (wr_sel_addr == h_cnt_t'(h_total - 1)) begin
            wr_addr <= wr_sel_addr;
         end else begin
            wr_addr <= wr_sel_addr + 1'b1;
         end
         if (swap) begin
            wr_vs_n <= vid.vsync_n;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Double rate replay
   ////////////////////////////////////////////////////////////////////////////

   assign vga_tick = (vga_cnt == vga_div - 1);
   assign rd_idx   = buf_addr_t'(rd_addr) + (rd_bank ? buf_addr_t'(h_total) : '0);

   // Restart on every swap so both replays fit one source line
   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         vga_cnt <= '0;
         rd_addr <= '0;
         rd_bank <= 1'b1;
         replay  <= 1'b0;
         rd_vs_n <= 1'b1;
      end else if (swap) begin
         vga_cnt <= '0;
         rd_addr <= '0;
         rd_bank <= wr_bank;
         replay  <= 1'b0;
         rd_vs_n <= wr_vs_n;
      end else begin
         if (vga_tick) begin
            vga_cnt <= '0;
            if (rd_addr == h_cnt_t'(h_total - 1)) begin
               rd_addr <= '0;
               replay  <= ~replay;
            end else begin
               rd_addr <= rd_addr + 1'b1;
            end
         end else begin
            vga_cnt <= vga_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk28) begin
      dbl_pix <= line_buf[rd_idx];
   end

   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         dbl_hs_n <= 1'b1;
         dbl_vs_n <= 1'b1;
         dbl_dim  <= 1'b0;
      end else begin
         dbl_hs_n <= !(rd_addr < h_sync_len);
         dbl_vs_n <= rd_vs_n;
         dbl_dim  <= scanlines_enable && replay;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output select
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk28) begin
      if (vga_enable) begin
         out_pix <= dbl_dim ? dim_pixel(dbl_pix) : dbl_pix;
      end else begin
         out_pix <= vid.pix;
      end
   end

   // Pass-through sends csync on hsync and parks vsync high
   always_ff @(posedge clk28) begin
      if (!rst_n) begin
         hsync <= 1'b1;
         vsync <= 1'b1;
      end else if (vga_enable) begin
         hsync <= dbl_hs_n;
         vsync <= dbl_vs_n;
      end else begin
         hsync <= vid.csync_n;
         vsync <= 1'b1;
      end
   end

   assign r = out_pix.r;
   assign g = out_pix.g;
   assign b = out_pix.b;

   // Replay must never read the bank being filled
   a_bank_split: assert property (
      @(posedge clk28) disable iff (!rst_n)
      swap |=> (rd_bank != wr_bank)
   );

endmodule

//--- hdl/video_top.sv
`timescale 1ns/100ps

module video_top
   import zxvideo_pkg::*;
(
   input  logic       clk28,
   input  logic       rst_n,

   // Wishbone classic host port
   input  logic       cyc,
   input  logic       stb,
   input  logic       we,
   input  wb_addr_t   adr,
   input  wb_data_t   dat_w,
   output wb_data_t   dat_r,
   output logic       ack,

   // Video out
   output logic [2:0] r,
   output logic [2:0] g,
   output logic [2:0] b,
   output logic       hsync,
   output logic       vsync
);

   video_if vid ();

   logic   vga_enable;
   logic   scanlines_enable;
   logic   frame_start;
   pixel_t border;

   wb_video_regs u_regs (
      .clk28            (clk28),
      .rst_n            (rst_n),
      .cyc              (cyc),
      .stb              (stb),
      .we               (we),
      .adr              (adr),
      .dat_w            (dat_w),
      .dat_r            (dat_r),
      .ack              (ack),
      .frame_start      (frame_start),
      .vga_enable       (vga_enable),
      .scanlines_enable (scanlines_enable),
      .border           (border)
   );

   // Stands in for the machine core video
   pal_timing_gen u_src (
      .clk28       (clk28),
      .rst_n       (rst_n),
      .border      (border),
      .frame_start (frame_start),
      .vid         (vid.src)
   );

   vga_scandoubler u_scandbl (
      .clk28            (clk28),
      .rst_n            (rst_n),
      .vid              (vid.snk),
      .vga_enable       (vga_enable),
      .scanlines_enable (scanlines_enable),
      .r                (r),
      .g                (g),
      .b                (b),
      .hsync            (hsync),
      .vsync            (vsync)
   );

endmodule

//--- verif/tb_video_top.sv
`timescale 1ns/100ps

module tb_video_top
   import zxvideo_pkg::*;
();

   localparam int line_cycles  = h_total * src_div;
   localparam int frame_cycles = line_cycles * v_total;
   localparam int ack_limit    = 16;
   localparam int n_rows       = 4;
   // Border sample plus one sample in the middle of each bar
   localparam int n_samples    = 9;

   logic     clk28 = 1'b0;
   logic     rst_n;
   logic     cyc;
   logic     stb;
   logic     we;
   wb_addr_t adr;
   wb_data_t dat_w;
   wb_data_t dat_r;
   logic     ack;
   logic [2:0] r;
   logic [2:0] g;
   logic [2:0] b;
   logic     hsync;
   logic     vsync;

   // Stimulus table with one test per row
   string    row_name   [0:n_rows-1] = '{"pass_fixed", "double_plain",
                                          "double_scanlines", "pass_scan_bit"};
   wb_data_t row_ctrl   [0:n_rows-1] = '{16'h0000, 16'h0001, 16'h0003, 16'h0002};
   bit       row_random [0:n_rows-1] = '{1'b0, 1'b1, 1'b1, 1'b1};
   pixel_t   row_border [0:n_rows-1] = '{9'h1a5, 9'h000, 9'h000, 9'h000};

   logic [15:0] lfsr = 16'd40850;
   pixel_t      seen [0:2*n_samples-1];
   string       cur_test;
   int          test_errs = 0;
   int          err_cnt = 0;
   int          check_cnt = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   video_top u_video_top (
      .clk28 (clk28),
      .rst_n (rst_n),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack),
      .r     (r),
      .g     (g),
      .b     (b),
      .hsync (hsync),
      .vsync (vsync)
   );

   always #5 clk28 = ~clk28;

   ////////////////////////////////////////////////////////////////////////////
   // Expected values and random border colours
   ////////////////////////////////////////////////////////////////////////////

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   task automatic next_random_border(output pixel_t p);
      logic [8:0] bits;
      bits = '0;
      for (int i = 0; i < 9; i++) begin
         lfsr = lfsr_next(lfsr);
         bits = {bits[7:0], lfsr[0]};
      end
      p = bits;
   endtask

   function automatic pixel_t bar_colour(input int k);
      pixel_t p;
      p.r = (k & 4) ? 3'd7 : 3'd0;
      p.g = (k & 2) ? 3'd7 : 3'd0;
      p.b = (k & 1) ? 3'd7 : 3'd0;
      return p;
   endfunction

   // Whole word shifted down, then the top bit of each field cleared
   function automatic pixel_t dim_colour(input pixel_t p);
      logic [8:0] w;
      w = p;
      return (w >> 1) & 9'b011_011_011;
   endfunction

   // Pixel index from the sync start
   // Sample 0 lands in the left border
   function automatic int sample_pos(input int i);
      if (i == 0) begin
         return h_active_start / 2;
      end
      return h_active_start + (i - 1) * bar_width + bar_width / 2;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Checks and test bookkeeping
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_pixel(input string what, input pixel_t exp, input pixel_t act);
      check_cnt++;
      if (act !== exp) begin
         err_cnt++;
         test_errs++;
         $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_word(input string what, input wb_data_t exp, input wb_data_t act);
      check_cnt++;
      if (act !== exp) begin
         err_cnt++;
         test_errs++;
         $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      check_cnt++;
      if (act != exp) begin
         err_cnt++;
         test_errs++;
         $display("ERROR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      end
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("TEST %s: pass", cur_test);
      end else begin
         tests_failed++;
         $display("TEST %s: %0d errors", cur_test, test_errs);
      end
   endtask

   task automatic abort_run(input string what);
      $display("Timeout in test %s: %s", cur_test, what);
      $display("CHECKS FAILED");
      $finish;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus and raster helpers stepping on the falling edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic wb_access(input logic write, input wb_addr_t addr, input wb_data_t wdata,
                            output wb_data_t rdata);
      int waited;
      int acks;
      waited = 0;
      @(negedge clk28);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = addr;
      dat_w = wdata;
      @(negedge clk28);
      while (!ack) begin
         waited++;
         if (waited > ack_limit) begin
            abort_run("the Wishbone slave never raised ack");
         end
         @(negedge clk28);
      end
      acks  = 1;
      rdata = dat_r;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      // A stuck ack would still be high here
      @(negedge clk28);
      if (ack) begin
         acks++;
      end
      check_count("ack count", 1, acks);
   endtask

   task automatic wait_frame();
      wb_data_t start;
      wb_data_t now;
      int polls;
      polls = 0;
      wb_access(1'b0, reg_frame_addr, '0, start);
      now = start;
      while (now == start) begin
         polls++;
         if (polls > frame_cycles / 2) begin
            abort_run("the frame counter did not advance");
         end
         wb_access(1'b0, reg_frame_addr, '0, now);
      end
      check_word("frame step", (start + 16'd1) & 16'h00ff, now);
   endtask

   // One whole frame window makes the count independent of the phase
   task automatic count_syncs(output int hs_falls, output int vs_low);
      logic hs_last;
      hs_falls = 0;
      vs_low   = 0;
      hs_last  = hsync;
      for (int i = 0; i < frame_cycles; i++) begin
         @(negedge clk28);
         if (hs_last && !hsync) begin
            hs_falls++;
         end
         if (!vsync) begin
            vs_low++;
         end
         hs_last = hsync;
      end
   endtask

   task automatic wait_hsync_fall();
      logic last;
      logic fell;
      int waited;
      fell   = 1'b0;
      waited = 0;
      while (!fell) begin
         last = hsync;
         @(negedge clk28);
         fell = last && !hsync;
         waited++;
         if (!fell && waited > 8 * line_cycles) begin
            abort_run("no falling edge on the output hsync");
         end
      end
   endtask

   task automatic wait_vsync_rise();
      logic last;
      logic rose;
      int waited;
      rose   = 1'b0;
      waited = 0;
      while (!rose) begin
         last = vsync;
         @(negedge clk28);
         rose = !last && vsync;
         waited++;
         if (!rose && waited > frame_cycles) begin
            abort_run("no rising edge on the output vsync");
         end
      end
   endtask

   // Lands on a first replay hsync fall well inside the active lines
   task automatic find_active_line(input logic doubled);
      if (doubled) begin
         // Vsync rises together with a first replay hsync
         wait_vsync_rise();
         repeat (2 * 120) wait_hsync_fall();
      end else begin
         repeat (120) wait_hsync_fall();
      end
   endtask

   task automatic capture_replay(input int div, input int rep);
      int waited;
      int target;
      waited = 0;
      for (int i = 0; i < n_samples; i++) begin
         target = sample_pos(i) * div + div / 2;
         while (waited < target) begin
            @(negedge clk28);
            waited++;
         end
         seen[rep * n_samples + i] = {r, g, b};
      end
   endtask

   task automatic check_replay(input int rep, input logic dim, input pixel_t border_exp);
      pixel_t exp;
      for (int i = 0; i < n_samples; i++) begin
         exp = (i == 0) ? border_exp : bar_colour(i - 1);
         if (dim) begin
            exp = dim_colour(exp);
         end
         check_pixel($sformatf("replay %0d sample %0d", rep, i), exp,
                     seen[rep * n_samples + i]);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      wb_data_t rd;
      pixel_t   bdr;
      int       hs_falls;
      int       vs_low;
      logic     vga;
      logic     scan;
      rst_n = 1'b0;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      dat_w = '0;
      repeat (8) @(negedge clk28);
      rst_n = 1'b1;

      // Frame counter first since it steps a few clocks after reset
      begin_test("reset_values");
      wb_access(1'b0, reg_frame_addr, '0, rd);
      check_word("frame after reset", '0, rd);
      // Ignored write, so ctrl and border still read as zero
      wb_access(1'b1, 2'd3, 16'hffff, rd);
      wb_access(1'b0, reg_ctrl_addr, '0, rd);
      check_word("ctrl after reset", '0, rd);
      wb_access(1'b0, reg_border_addr, '0, rd);
      check_word("border after reset", '0, rd);
      wb_access(1'b0, 2'd3, '0, rd);
      check_word("unused address", '0, rd);
      end_test();

      for (int n = 0; n < n_rows; n++) begin
         begin_test(row_name[n]);
         if (row_random[n]) begin
            next_random_border(bdr);
         end else begin
            bdr = row_border[n];
         end
         vga  = row_ctrl[n][0];
         scan = row_ctrl[n][1];
         wb_access(1'b1, reg_ctrl_addr, row_ctrl[n], rd);
         wb_access(1'b1, reg_border_addr, wb_data_t'(bdr), rd);
         wb_access(1'b0, reg_ctrl_addr, '0, rd);
         check_word("ctrl readback", row_ctrl[n], rd);
         wb_access(1'b0, reg_border_addr, '0, rd);
         check_word("border readback", wb_data_t'(bdr), rd);

         wait_frame();
         count_syncs(hs_falls, vs_low);
         // Composite sync stays low through the vertical sync lines
         check_count("hsync falls", vga ? 2 * v_total : v_total - v_sync_len, hs_falls);
         check_count("vsync low clocks", vga ? 2 * v_sync_len * h_total * vga_div : 0,
                     vs_low);

         find_active_line(vga);
         capture_replay(vga ? vga_div : src_div, 0);
         check_replay(0, 1'b0, bdr);
         if (vga) begin
            wait_hsync_fall();
            capture_replay(vga_div, 1);
            check_replay(1, scan, bdr);
         end
         end_test();
      end

      $display("Tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
               tests_run, tests_failed, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- flist.f
hdl/zxvideo_pkg.sv
hdl/video_if.sv
hdl/wb_video_regs.sv
hdl/pal_timing_gen.sv
hdl/vga_scandoubler.sv
hdl/video_top.sv
verif/tb_video_top.sv

//--- Bender.yml
package:
  name: zxvideo

sources:
  - hdl/zxvideo_pkg.sv
  - hdl/video_if.sv
  - hdl/wb_video_regs.sv
  - hdl/pal_timing_gen.sv
  - hdl/vga_scandoubler.sv
  - hdl/video_top.sv
  - target: test
    files:
      - verif/tb_video_top.sv
